//--- design/ntm_exp_pkg.sv
package ntm_exp_pkg;

  //////////////////////////////////////////////////
  // Data format
  //////////////////////////////////////////////////

  // Word width and binary point of Q16.16
  localparam int DATA_SIZE = 32;
  localparam int FRAC_BITS = 16;

  typedef logic signed [DATA_SIZE-1:0] data_t;

  // 1.0 in Q16.16
  localparam data_t ONE_DATA = 65536;

  // Operand clamp, -2.0 up to 2.0 minus one LSB
  localparam data_t X_MAX = 2 * ONE_DATA - 1;
  localparam data_t X_MIN = -2 * ONE_DATA;

  //////////////////////////////////////////////////
  // Series length and term index
  //////////////////////////////////////////////////

  // Terms after the constant 1.0
  localparam int TERM_COUNT = 12;
  localparam int COUNT_SIZE = 4;

  typedef logic [COUNT_SIZE-1:0] count_t;

  // floor(65536 / k), k = 1 .. 12
  localparam data_t RECIP_TABLE [1:TERM_COUNT] = '{
    65536, 32768, 21845, 16384,
    13107, 10922,  9362,  8192,
     7281,  6553,  5957,  5461
  };

  //////////////////////////////////////////////////
  // Control encodings
  //////////////////////////////////////////////////

  // Three cycles per term, then one cycle to publish
  typedef enum logic [2:0] {
    IDLE,
    MUL_X,
    MUL_RECIP,
    ACCUM,
    DONE
  } exp_state_t;

  // Second multiplier operand
  typedef enum logic {
    MUL_BY_X,
    MUL_BY_RECIP
  } mul_op_t;

endpackage

//--- design/ntm_exp_ctrl_if.sv
`timescale 1ns/10ps

interface ntm_exp_ctrl_if import ntm_exp_pkg::*; ();

  // Strobes from the FSM
  logic    load;
  logic    mul_en;
  mul_op_t mul_op;
  logic    accum;
  logic    finish;

  // Term counter status
  count_t  index;
  logic    last;

  // Sequencer side
  modport fsm (
    output load, mul_en, mul_op, accum, finish,
    input  index, last
  );

  // Term index counter
  modport counter (
    input  load, accum,
    output index, last
  );

  // Multiplier and accumulator
  modport datapath (
    input load, mul_en, mul_op, accum, finish, index
  );

endinterface

//--- design/ntm_exp_fsm.sv
`timescale 1ns/10ps

module ntm_exp_fsm import ntm_exp_pkg::*; (
  input  logic        CLK,
  input  logic        RST,
  input  logic        START,
  output logic        READY,
  ntm_exp_ctrl_if.fsm ctrl
);

  exp_state_t state;
  exp_state_t state_next;

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        // START only counts here
        if (START) begin
          state_next = MUL_X;
        end
      end
      MUL_X: begin
        state_next = MUL_RECIP;
      end
      MUL_RECIP: begin
        state_next = ACCUM;
      end
      ACCUM: begin
        // Twelfth term just summed
        if (ctrl.last) begin
          state_next = DONE;
        end else begin
          state_next = MUL_X;
        end
      end
      DONE: begin
        state_next = IDLE;
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // State and READY registers
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= IDLE;
      READY <= 1'b0;
    end else begin
      state <= state_next;
      // Lines up with DATA_OUT written by finish
      READY <= (state == DONE);
    end
  end

  // Datapath strobes, decoded from state
  assign ctrl.load   = (state == IDLE) && START;
  assign ctrl.mul_en = (state == MUL_X) || (state == MUL_RECIP);
  assign ctrl.mul_op = (state == MUL_RECIP) ? MUL_BY_RECIP : MUL_BY_X;
  assign ctrl.accum  = (state == ACCUM);
  assign ctrl.finish = (state == DONE);

  // One READY per completion
  a_ready_single: assert property (
    @(posedge CLK) disable iff (RST) READY |=> !READY
  );

  // Busy START neither restarts the walk nor reloads the counter
  // After ACCUM the index moves on, so a reload shows up as k = 1
  a_busy_start: assert property (
    @(posedge CLK) disable iff (RST)
    (START && (state != IDLE))
      |=> ($past(state) == ACCUM) ? (ctrl.index != count_t'(1))
          : ((state != MUL_X) && (ctrl.index == $past(ctrl.index)))
  );

endmodule

//--- design/ntm_term_counter.sv
`timescale 1ns/10ps

module ntm_term_counter import ntm_exp_pkg::*; (
  input  logic            CLK,
  input  logic            RST,
  ntm_exp_ctrl_if.counter ctrl
);

  //////////////////////////////////////////////////
  // Term index k
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ctrl.index <= '0;
    end else if (ctrl.load) begin
      // First term is k = 1
      ctrl.index <= count_t'(1);
    end else if (ctrl.accum && !ctrl.last) begin
      ctrl.index <= ctrl.index + count_t'(1);
    end
  end

  // Holds at TERM_COUNT after the last accumulate
  assign ctrl.last = (ctrl.index == count_t'(TERM_COUNT));

  // Stays inside the reciprocal table
  a_index_range: assert property (
    @(posedge CLK) disable iff (RST) ctrl.index <= count_t'(TERM_COUNT)
  );

endmodule

//--- design/ntm_fixed_multiplier.sv
`timescale 1ns/10ps

module ntm_fixed_multiplier import ntm_exp_pkg::*; (
  input  logic             CLK,
  input  logic             RST,
  ntm_exp_ctrl_if.datapath ctrl,
  input  data_t            term,
  input  data_t            x_reg,
  output data_t            product
);

  data_t                       op_a;
  data_t                       op_b;
  logic signed [2*DATA_SIZE-1:0] full_product;

  //////////////////////////////////////////////////
  // Operand select
  //////////////////////////////////////////////////

  always_comb begin
    if (ctrl.mul_op == MUL_BY_RECIP) begin
      // Second step of a term, scale by 1/k
      op_a = product;
      op_b = RECIP_TABLE[ctrl.index];
    end else begin
      // First step, previous term times x
      op_a = term;
      op_b = x_reg;
    end
  end

  // Full signed product, Q32.32
  assign full_product = op_a * op_b;

  //////////////////////////////////////////////////
  // Product register
  //////////////////////////////////////////////////

  // Arithmetic shift back to Q16.16, truncates toward minus infinity
  always_ff @(posedge CLK) begin
    if (ctrl.mul_en) begin
      product <= data_t'(full_product >>> FRAC_BITS);
    end
  end

  // Operand select must be defined when a product is taken
  a_mul_op_known: assert property (
    @(posedge CLK) disable iff (RST) ctrl.mul_en |-> !$isunknown(ctrl.mul_op)
  );

endmodule

//--- design/ntm_series_accumulator.sv
`timescale 1ns/10ps

module ntm_series_accumulator import ntm_exp_pkg::*; (
  input  logic             CLK,
  input  logic             RST,
  input  data_t            DATA_IN,
  ntm_exp_ctrl_if.datapath ctrl,
  input  data_t            product,
  output data_t            term,
  output data_t            x_reg,
  output data_t            DATA_OUT
);

  data_t clamped;
  data_t sum;

  //////////////////////////////////////////////////
  // Operand clamp
  //////////////////////////////////////////////////

  // No range reduction, large inputs saturate
  always_comb begin
    if (DATA_IN > X_MAX) begin
      clamped = X_MAX;
    end else if (DATA_IN < X_MIN) begin
      clamped = X_MIN;
    end else begin
      clamped = DATA_IN;
    end
  end

  //////////////////////////////////////////////////
  // Term and partial sum
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (ctrl.load) begin
      // Series starts at 1.0
      x_reg <= clamped;
      term  <= ONE_DATA;
      sum   <= ONE_DATA;
    end else if (ctrl.accum) begin
      // Product holds x^k / k!
      term <= product;
      sum  <= sum + product;
    end
  end

  // Result register, held until next finish
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT <= '0;
    end else if (ctrl.finish) begin
      DATA_OUT <= sum;
    end
  end

endmodule

//--- design/ntm_scalar_exponentiator_function.sv
`timescale 1ns/10ps

module ntm_scalar_exponentiator_function import ntm_exp_pkg::*; (
  // Global
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  output logic  READY,

  // Data
  input  data_t DATA_IN,
  output data_t DATA_OUT
);

  // Datapath buses
  data_t term;
  data_t x_reg;
  data_t product;

  // Strobes and counter status
  ntm_exp_ctrl_if ctrl_if ();

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  ntm_exp_fsm fsm_inst (
    .CLK   (CLK),
    .RST   (RST),
    .START (START),
    .READY (READY),
    .ctrl  (ctrl_if.fsm)
  );

  ntm_term_counter counter_inst (
    .CLK  (CLK),
    .RST  (RST),
    .ctrl (ctrl_if.counter)
  );

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  // One multiplier, shared by both steps of each term
  ntm_fixed_multiplier multiplier_inst (
    .CLK     (CLK),
    .RST     (RST),
    .ctrl    (ctrl_if.datapath),
    .term    (term),
    .x_reg   (x_reg),
    .product (product)
  );

  ntm_series_accumulator accumulator_inst (
    .CLK      (CLK),
    .RST      (RST),
    .DATA_IN  (DATA_IN),
    .ctrl     (ctrl_if.datapath),
    .product  (product),
    .term     (term),
    .x_reg    (x_reg),
    .DATA_OUT (DATA_OUT)
  );

endmodule

//--- verif/ntm_exp_model.svh
`ifndef NTM_EXP_MODEL_SVH
`define NTM_EXP_MODEL_SVH

//////////////////////////////////////////////////
// Reference model
//////////////////////////////////////////////////

// Same clamp, order of products and truncation as the RTL
function automatic data_t model_exp(input data_t x_in);
  data_t                         x;
  data_t                         term;
  data_t                         sum;
  logic signed [2*DATA_SIZE-1:0] wide;
  begin
    // Saturate to the supported range
    if (x_in > X_MAX) begin
      x = X_MAX;
    end else if (x_in < X_MIN) begin
      x = X_MIN;
    end else begin
      x = x_in;
    end
    term = ONE_DATA;
    sum  = ONE_DATA;
    for (int k = 1; k <= TERM_COUNT; k++) begin
      // Previous term times x
      wide = term * x;
      term = data_t'(wide >>> FRAC_BITS);
      // Then times 1/k
      wide = term * RECIP_TABLE[k];
      term = data_t'(wide >>> FRAC_BITS);
      sum  = sum + term;
    end
    return sum;
  end
endfunction

//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

// Stops the run at the first difference
task automatic check_data(input string name, input data_t expected, input data_t actual);
  if (actual !== expected) begin
    $display("Mismatch on %s: expected %h, actual %h", name, expected, actual);
    $display("TESTBENCH FAILED");
    $fatal(1);
  end
endtask

task automatic check_ready(input string what, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("READY was %b but should be %b %s", actual, expected, what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  end
endtask

`endif

//--- verif/ntm_exp_tb.sv
`timescale 1ns/10ps

module ntm_exp_tb import ntm_exp_pkg::*; ();

  // Fixed latency from the START edge to READY
  localparam int LATENCY       = 37;
  localparam int READY_TIMEOUT = 100;
  localparam int RANDOM_COUNT  = 200;
  localparam int WILD_COUNT    = 20;
  localparam int BUSY_COUNT    = 10;

  // Operands outside -2.0 .. 2.0 - 1 LSB
  localparam data_t OUT_OF_RANGE [0:5] = '{
    32'sh7fffffff, 32'sh80000000, 32'sh00020000,
    32'shfffdffff, 32'sh00100000, 32'shfff00000
  };

  logic  CLK;
  logic  RST;
  logic  START;
  logic  READY;
  data_t DATA_IN;
  data_t DATA_OUT;

  integer      seed = 32'he76f;
  logic [31:0] rnd;
  data_t       last_result;

  `include "ntm_exp_model.svh"

  ntm_scalar_exponentiator_function ntm_scalar_exponentiator_function_inst (
    .CLK      (CLK),
    .RST      (RST),
    .START    (START),
    .READY    (READY),
    .DATA_IN  (DATA_IN),
    .DATA_OUT (DATA_OUT)
  );

  // 40 ns clock
  always #20 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Request and idle tasks
  //////////////////////////////////////////////////

  // One request, optionally with START noise while busy
  task automatic request(input data_t operand, input bit busy_noise);
    int          cycles;
    data_t       expected;
    logic [31:0] noise;
    expected = model_exp(operand);
    @(posedge CLK);
    #2;
    START   = 1'b1;
    DATA_IN = operand;
    // Accepting edge, counted as edge 0
    @(posedge CLK);
    #2;
    START   = 1'b0;
    // Must not be captured after acceptance
    DATA_IN = $random(seed);
    cycles  = 0;
    while (READY !== 1'b1) begin
      if (cycles >= READY_TIMEOUT) begin
        $display("Timed out waiting for READY after %0d cycles", cycles);
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
      @(posedge CLK);
      cycles++;
      #2;
      if (busy_noise && (cycles < LATENCY)) begin
        noise   = $random(seed);
        START   = noise[0];
        DATA_IN = $random(seed);
      end else begin
        // Quiet once the FSM is back in IDLE
        START = 1'b0;
      end
      @(negedge CLK);
      check_ready($sformatf("%0d cycles after START", cycles), cycles == LATENCY, READY);
      // Previous result holds while busy
      if (cycles != LATENCY) begin
        check_data("DATA_OUT", last_result, DATA_OUT);
      end
    end
    check_data("DATA_OUT", expected, DATA_OUT);
    last_result = expected;
  endtask

  // READY stays low and DATA_OUT holds
  task automatic hold_idle(input int n, input data_t held);
    repeat (n) begin
      @(posedge CLK);
      @(negedge CLK);
      check_ready("while idle", 1'b0, READY);
      check_data("DATA_OUT", held, DATA_OUT);
    end
  endtask

  // Random idle gap of 1 to 4 cycles
  task automatic random_gap();
    rnd = $random(seed);
    hold_idle(int'(rnd[1:0]) + 1, last_result);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    data_t operand;
    CLK         = 1'b0;
    RST         = 1'b1;
    START       = 1'b0;
    DATA_IN     = '0;
    last_result = '0;
    repeat (3) @(posedge CLK);
    #2;
    RST = 1'b0;

    // Quiet after reset
    repeat (2) begin
      @(negedge CLK);
      check_ready("after reset", 1'b0, READY);
      check_data("DATA_OUT", '0, DATA_OUT);
    end

    // exp(0) is exactly 1.0
    request('0, 1'b0);
    check_data("DATA_OUT", ONE_DATA, DATA_OUT);
    hold_idle(3, ONE_DATA);

    // Directed in-range corners
    request(ONE_DATA, 1'b0);
    random_gap();
    request(-ONE_DATA, 1'b0);
    random_gap();
    request(X_MAX, 1'b0);
    random_gap();
    request(X_MIN, 1'b0);
    random_gap();
    request(32'sh00000001, 1'b0);
    random_gap();
    request(32'shffffffff, 1'b0);
    random_gap();

    // Random in-range operands, both signs
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      operand = $random(seed) % 131072;
      request(operand, 1'b0);
      random_gap();
    end

    // Saturating operands
    for (int i = 0; i < 6; i++) begin
      request(OUT_OF_RANGE[i], 1'b0);
      random_gap();
    end
    for (int i = 0; i < WILD_COUNT; i++) begin
      operand = $random(seed);
      request(operand, 1'b0);
      random_gap();
    end

    // START noise while busy
    for (int i = 0; i < BUSY_COUNT; i++) begin
      operand = $random(seed) % 131072;
      request(operand, 1'b1);
      hold_idle(4, last_result);
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

  // Overall run limit
  initial begin
    #2ms;
    $display("Simulation ran past its time limit");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

endmodule

//--- list.f
+incdir+verif
design/ntm_exp_pkg.sv
design/ntm_exp_ctrl_if.sv
design/ntm_exp_fsm.sv
design/ntm_term_counter.sv
design/ntm_fixed_multiplier.sv
design/ntm_series_accumulator.sv
design/ntm_scalar_exponentiator_function.sv
verif/ntm_exp_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the exponential testbench with Verilator
# Exit status is nonzero when the build fails or the simulation stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f list.f \
  --top-module ntm_exp_tb \
  -o ntm_exp_sim \
  && ./obj_dir/ntm_exp_sim \
  || { echo "Simulation build or run failed"; exit 1; }
